//--- lsu_pkg.sv
package lsu_pkg;

    // data and address width
    localparam int WORD_WIDTH = 32;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [3:0]            byteena_t;

    // scratchpad of 1024 words, 4 KiB
    localparam int SPM_ADDR_BITS = 10;

    typedef logic [SPM_ADDR_BITS-1:0] spm_addr_t;

    // address bits 31:12 that select the scratchpad, everything else is AHB
    localparam logic [19:0] SPM_REGION = 20'h10000;

    typedef enum logic [3:0] {
        MEM_NOP = 4'd0,
        MEM_LB  = 4'd1,
        MEM_LH  = 4'd2,
        MEM_LW  = 4'd3,
        MEM_LBU = 4'd4,
        MEM_LHU = 4'd5,
        MEM_SB  = 4'd6,
        MEM_SH  = 4'd7,
        MEM_SW  = 4'd8
    } mem_op_t;

    typedef enum logic [1:0] {
        EXP_NONE           = 2'd0,
        EXP_LOAD_MISALIGN  = 2'd1,
        EXP_STORE_MISALIGN = 2'd2,
        EXP_BUS_ERROR      = 2'd3
    } exp_code_t;

    // AHB-Lite encodings, only single transfers are issued
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_NONSEQ = 2'b10
    } htrans_t;

    typedef enum logic [2:0] {
        HSIZE_BYTE = 3'b000,
        HSIZE_HALF = 3'b001,
        HSIZE_WORD = 3'b010
    } hsize_t;

    localparam logic [1:0] HRESP_OKAY  = 2'b00;
    localparam logic [1:0] HRESP_ERROR = 2'b01;

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_SPM,
        LSU_AHB
    } lsu_state_t;

    typedef enum logic [1:0] {
        AHB_IDLE,
        AHB_ADDR,
        AHB_DATA
    } ahb_state_t;

endpackage

//--- lsu_align.sv
`timescale 1ns/1ps

module lsu_align (
    input  lsu_pkg::mem_op_t   op,
    input  logic [1:0]         addr_lsb,
    input  lsu_pkg::word_t     wdata,
    input  lsu_pkg::word_t     raw_rdata,
    output lsu_pkg::byteena_t  byteena,
    output lsu_pkg::word_t     store_word,
    output lsu_pkg::hsize_t    hsize,
    output lsu_pkg::exp_code_t misalign,
    output lsu_pkg::word_t     load_value
);
    import lsu_pkg::*;

    logic        is_store;
    logic        is_load;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    assign is_store = op inside {MEM_SB, MEM_SH, MEM_SW};
    assign is_load  = op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};

    // access size
    always_comb begin
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: hsize = HSIZE_BYTE;
            MEM_LH, MEM_LHU, MEM_SH: hsize = HSIZE_HALF;
            default:                 hsize = HSIZE_WORD;
        endcase
    end

    // lanes touched by the access
    always_comb begin
        case (hsize)
            HSIZE_BYTE: byteena = 4'b0001 << addr_lsb;
            HSIZE_HALF: byteena = addr_lsb[1] ? 4'b1100 : 4'b0011;
            default:    byteena = 4'b1111;
        endcase
        if (!is_store && !is_load) begin
            byteena = 4'b0000;
        end
    end

    // store data copied into every lane, byte enables pick the right one
    always_comb begin
        case (hsize)
            HSIZE_BYTE: store_word = {4{wdata[7:0]}};
            HSIZE_HALF: store_word = {2{wdata[15:0]}};
            default:    store_word = wdata;
        endcase
    end

    always_comb begin
        misalign = EXP_NONE;
        if ((hsize == HSIZE_HALF && addr_lsb[0]) ||
            (hsize == HSIZE_WORD && addr_lsb != 2'b00)) begin
            if (is_load) begin
                misalign = EXP_LOAD_MISALIGN;
            end else if (is_store) begin
                misalign = EXP_STORE_MISALIGN;
            end
        end
    end

    // addressed lane of the returned word
    assign lane_byte = raw_rdata[{addr_lsb, 3'b000} +: 8];
    assign lane_half = addr_lsb[1] ? raw_rdata[31:16] : raw_rdata[15:0];

    always_comb begin
        case (op)
            MEM_LB:  load_value = {{24{lane_byte[7]}}, lane_byte};
            MEM_LBU: load_value = {24'h000000, lane_byte};
            MEM_LH:  load_value = {{16{lane_half[15]}}, lane_half};
            MEM_LHU: load_value = {16'h0000, lane_half};
            MEM_LW:  load_value = raw_rdata;
            default: load_value = '0;
        endcase
    end

endmodule

//--- spm.sv
`timescale 1ns/1ps

module spm (
    input  logic               clk,
    input  logic               en,
    input  logic               we,
    input  lsu_pkg::byteena_t  byteena,
    input  lsu_pkg::spm_addr_t word_addr,
    input  lsu_pkg::word_t     wdata,
    output lsu_pkg::word_t     rdata
);
    import lsu_pkg::*;

    word_t mem [2**SPM_ADDR_BITS];

    // byte-masked write, registered read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int i = 0; i < 4; i++) begin
                    if (byteena[i]) begin
                        mem[word_addr][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata <= mem[word_addr];
            end
        end
    end

    // rdata keeps the last read word across writes and idle cycles

endmodule

//--- ahb_master.sv
`timescale 1ns/1ps

module ahb_master (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic             write,
    input  lsu_pkg::word_t   addr,
    input  lsu_pkg::hsize_t  size,
    input  lsu_pkg::word_t   wdata,
    input  lsu_pkg::word_t   hrdata,
    input  logic             hready,
    input  logic [1:0]       hresp,
    output logic             xfer_done,
    output lsu_pkg::word_t   xfer_rdata,
    output logic             xfer_err,
    output lsu_pkg::word_t   haddr,
    output logic             hwrite,
    output lsu_pkg::hsize_t  hsize,
    output lsu_pkg::htrans_t htrans,
    output lsu_pkg::word_t   hwdata
);
    import lsu_pkg::*;

    ahb_state_t state;
    // direction of the transfer now in its data phase
    logic       data_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= AHB_IDLE;
            htrans     <= HTRANS_IDLE;
            hwrite     <= 1'b0;
            data_write <= 1'b0;
        end else begin
            case (state)
                AHB_IDLE: begin
                    if (start) begin
                        state      <= AHB_ADDR;
                        htrans     <= HTRANS_NONSEQ;
                        hwrite     <= write;
                        data_write <= write;
                    end
                end
                AHB_ADDR: begin
                    // address phase held until the slave takes it
                    if (hready) begin
                        state  <= AHB_DATA;
                        htrans <= HTRANS_IDLE;
                        hwrite <= 1'b0;
                    end
                end
                AHB_DATA: begin
                    if (hready) begin
                        state <= AHB_IDLE;
                    end
                end
                default: begin
                    state <= AHB_IDLE;
                end
            endcase
        end
    end

    // haddr, hsize and hwdata stay stable until the next start
    always_ff @(posedge clk) begin
        if (state == AHB_IDLE && start) begin
            haddr  <= addr;
            hsize  <= size;
            hwdata <= wdata;
        end
    end

    // end of the data phase, the slave response is valid in this cycle
    assign xfer_done = (state == AHB_DATA) && hready;

    // second cycle of the two-cycle error response
    assign xfer_err = xfer_done && (hresp == HRESP_ERROR);

    // hrdata carries nothing on a write
    assign xfer_rdata = data_write ? '0 : hrdata;

endmodule

//--- load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  lsu_pkg::mem_op_t    op,
    input  lsu_pkg::word_t      addr,
    input  lsu_pkg::word_t      wdata,
    input  lsu_pkg::word_t      hrdata,
    input  logic                hready,
    input  logic [1:0]          hresp,
    output logic                busy,
    output logic                done,
    output lsu_pkg::word_t      rdata,
    output lsu_pkg::exp_code_t  exp_code,
    output lsu_pkg::word_t      haddr,
    output logic                hwrite,
    output lsu_pkg::hsize_t     hsize,
    output lsu_pkg::htrans_t    htrans,
    output lsu_pkg::word_t      hwdata
);
    import lsu_pkg::*;

    lsu_state_t state;
    logic       spm_pend;
    mem_op_t    op_r;
    word_t      addr_r;
    word_t      wdata_r;

    mem_op_t    cur_op;
    word_t      cur_addr;
    word_t      cur_wdata;
    word_t      raw_rdata;
    byteena_t   byteena;
    word_t      store_word;
    hsize_t     acc_size;
    exp_code_t  misalign;
    word_t      load_value;
    word_t      spm_rdata;
    logic       spm_en;
    logic       spm_we;
    logic       spm_hit;
    logic       is_store;
    logic       is_load;
    logic       spm_go;
    logic       ahb_start;
    logic       xfer_done;
    word_t      xfer_rdata;
    logic       xfer_err;

    assign busy = (state != LSU_IDLE);

    // incoming request while idle, latched one while busy
    assign cur_op    = busy ? op_r : op;
    assign cur_addr  = busy ? addr_r : addr;
    assign cur_wdata = busy ? wdata_r : wdata;

    assign is_store = cur_op inside {MEM_SB, MEM_SH, MEM_SW};
    assign is_load  = cur_op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
    assign spm_hit  = (cur_addr[WORD_WIDTH-1:SPM_ADDR_BITS+2] == SPM_REGION);

    assign spm_go    = (misalign == EXP_NONE) && (is_load || is_store) && spm_hit;
    assign ahb_start = !busy && req && (misalign == EXP_NONE) &&
                       (is_load || is_store) && !spm_hit;

    // one scratchpad cycle right after the request edge
    assign spm_en = (state == LSU_SPM) && spm_pend;
    assign spm_we = spm_en && is_store;

    assign raw_rdata = (state == LSU_AHB) ? xfer_rdata : spm_rdata;

    lsu_align u_lsu_align (
        .op         (cur_op          ),
        .addr_lsb   (cur_addr[1:0]   ),
        .wdata      (cur_wdata       ),
        .raw_rdata  (raw_rdata       ),
        .byteena    (byteena         ),
        .store_word (store_word      ),
        .hsize      (acc_size        ),
        .misalign   (misalign        ),
        .load_value (load_value      )
    );

    spm u_spm (
        .clk        (clk                        ),
        .en         (spm_en                     ),
        .we         (spm_we                     ),
        .byteena    (byteena                    ),
        .word_addr  (addr_r[SPM_ADDR_BITS+1:2]  ),
        .wdata      (store_word                 ),
        .rdata      (spm_rdata                  )
    );

    ahb_master u_ahb_master (
        .clk        (clk        ),
        .rst_n      (rst_n      ),
        .start      (ahb_start  ),
        .write      (is_store   ),
        .addr       (addr       ),
        .size       (acc_size   ),
        .wdata      (store_word ),
        .hrdata     (hrdata     ),
        .hready     (hready     ),
        .hresp      (hresp      ),
        .xfer_done  (xfer_done  ),
        .xfer_rdata (xfer_rdata ),
        .xfer_err   (xfer_err   ),
        .haddr      (haddr      ),
        .hwrite     (hwrite     ),
        .hsize      (hsize      ),
        .htrans     (htrans     ),
        .hwdata     (hwdata     )
    );

    // misaligned and NOP requests pass through LSU_SPM with no access and finish a cycle early
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= LSU_IDLE;
            spm_pend <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                LSU_IDLE: begin
                    if (req) begin
                        state    <= ahb_start ? LSU_AHB : LSU_SPM;
                        spm_pend <= spm_go;
                    end
                end
                LSU_SPM: begin
                    spm_pend <= 1'b0;
                    if (!spm_pend) begin
                        done  <= 1'b1;
                        state <= LSU_IDLE;
                    end
                end
                LSU_AHB: begin
                    if (xfer_done) begin
                        done  <= 1'b1;
                        state <= LSU_IDLE;
                    end
                end
                default: begin
                    state <= LSU_IDLE;
                end
            endcase
        end
    end

    // request latch and result
    always_ff @(posedge clk) begin
        if (!busy && req) begin
            op_r    <= op;
            addr_r  <= addr;
            wdata_r <= wdata;
        end
        if (state == LSU_SPM && !spm_pend) begin
            exp_code <= misalign;
            rdata    <= (is_load && misalign == EXP_NONE) ? load_value : '0;
        end
        if (state == LSU_AHB && xfer_done) begin
            exp_code <= xfer_err ? EXP_BUS_ERROR : EXP_NONE;
            rdata    <= (is_load && !xfer_err) ? load_value : '0;
        end
    end

endmodule

//--- lsu_assertions.sv
`timescale 1ns/1ps

module lsu_assertions (
    input logic             clk,
    input logic             rst_n,
    input logic             req,
    input logic             busy,
    input logic             done,
    input logic             hready,
    input lsu_pkg::htrans_t htrans
);
    import lsu_pkg::*;

    // done is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

    assert property (@(posedge clk) disable iff (!rst_n) busy |-> !req)
        else $error("req arrived while busy was high");

    // a stalled phase keeps its transfer type
    assert property (@(posedge clk) disable iff (!rst_n) !hready |=> $stable(htrans))
        else $error("htrans changed while hready was low");

    assert property (@(posedge clk) !rst_n |=> (!busy && !done && htrans == HTRANS_IDLE))
        else $error("busy, done or htrans not idle after reset");

endmodule

bind load_store_unit lsu_assertions u_lsu_assertions (
    .clk    (clk   ),
    .rst_n  (rst_n ),
    .req    (req   ),
    .busy   (busy  ),
    .done   (done  ),
    .hready (hready),
    .htrans (htrans)
);

//--- tb_load_store_unit.sv
`timescale 1ns/1ps

module tb_load_store_unit;
    import lsu_pkg::*;

    localparam int    NUM_OPS     = 400;
    localparam int    TIMEOUT     = 200;
    localparam int    SPM_WORDS   = 32;
    // AHB window of 40 words whose top 8 answer with ERROR
    localparam int    AHB_WORDS   = 40;
    localparam int    ERR_FIRST   = 32;
    localparam int    WAIT_ONE_IN = 4;
    localparam word_t SPM_BASE    = 32'h1000_0000;
    localparam word_t AHB_BASE    = 32'h2000_0000;

    logic       clk;
    logic       rst_n;
    logic       req;
    mem_op_t    op;
    word_t      addr;
    word_t      wdata;
    word_t      hrdata;
    logic       hready;
    logic [1:0] hresp;
    logic       busy;
    logic       done;
    word_t      rdata;
    exp_code_t  exp_code;
    word_t      haddr;
    logic       hwrite;
    hsize_t     hsize;
    htrans_t    htrans;
    word_t      hwdata;

    integer     seed;
    int         errors;
    bit         timed_out;
    word_t      ref_spm [64];
    word_t      ref_ahb [64];
    word_t      ahb_mem [64];

    // slave data phase in progress
    bit         dp_active;
    bit         dp_write;
    bit         dp_err;
    int         dp_wait;
    word_t      dp_addr;
    hsize_t     dp_size;

    // request that the next address phase must carry
    word_t      exp_addr;
    logic       exp_write;
    hsize_t     exp_size;
    word_t      exp_wdata;

    load_store_unit dut (
        .clk      (clk     ),
        .rst_n    (rst_n   ),
        .req      (req     ),
        .op       (op      ),
        .addr     (addr    ),
        .wdata    (wdata   ),
        .hrdata   (hrdata  ),
        .hready   (hready  ),
        .hresp    (hresp   ),
        .busy     (busy    ),
        .done     (done    ),
        .rdata    (rdata   ),
        .exp_code (exp_code),
        .haddr    (haddr   ),
        .hwrite   (hwrite  ),
        .hsize    (hsize   ),
        .htrans   (htrans  ),
        .hwdata   (hwdata  )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // bit mask of the byte lanes an access of this size touches
    function automatic word_t lane_bits(input hsize_t sz, input logic [1:0] lsb);
        int    nbytes;
        word_t m;
        nbytes = 1 << int'(sz);
        m      = '0;
        for (int j = 0; j < 4; j++) begin
            if (j >= int'(lsb) && j < int'(lsb) + nbytes) begin
                m[8*j +: 8] = 8'hff;
            end
        end
        return m;
    endfunction

    // store data moved up to the addressed byte lane
    function automatic word_t shift_to_lane(input word_t d, input logic [1:0] lsb);
        return d << {lsb, 3'b000};
    endfunction

    function automatic word_t extend_load(input mem_op_t o, input word_t w, input logic [1:0] lsb);
        word_t sh;
        sh = w >> {lsb, 3'b000};
        case (o)
            MEM_LB:  return {{24{sh[7]}}, sh[7:0]};
            MEM_LBU: return {24'h000000, sh[7:0]};
            MEM_LH:  return {{16{sh[15]}}, sh[15:0]};
            MEM_LHU: return {16'h0000, sh[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t want);
        assert (got === want) else begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, want);
        end
    endtask

    // AHB slave model stepped on every falling edge
    task automatic ahb_slave_step();
        int    idx;
        word_t mk;
        idx    = int'(dp_addr[7:2]);
        mk     = lane_bits(dp_size, dp_addr[1:0]);
        hresp  = HRESP_OKAY;
        hready = 1'b1;
        if (dp_active) begin
            if (dp_err) begin
                hresp = HRESP_ERROR;
            end
            if (dp_wait > 0) begin
                hready = 1'b0;
                dp_wait--;
            end else begin
                dp_active = 1'b0;
                if (!dp_err && dp_write) begin
                    check_value("hwdata", hwdata & mk,
                                shift_to_lane(exp_wdata, exp_addr[1:0]) & mk);
                    ahb_mem[idx] = (ahb_mem[idx] & ~mk) | (hwdata & mk);
                end else if (!dp_err) begin
                    hrdata = ahb_mem[idx];
                end
            end
        end else if (htrans == HTRANS_NONSEQ) begin
            if (rand_below(WAIT_ONE_IN) == 0) begin
                hready = 1'b0;
            end else begin
                check_value("haddr", haddr, exp_addr);
                check_value("hwrite", 32'(hwrite), 32'(exp_write));
                check_value("hsize", 32'(hsize), 32'(exp_size));
                dp_active = 1'b1;
                dp_write  = hwrite;
                dp_addr   = haddr;
                dp_size   = hsize;
                dp_err    = int'(haddr[7:2]) >= ERR_FIRST;
                // two-cycle error response or 0 to 3 wait states
                dp_wait   = dp_err ? 1 : rand_below(4);
            end
        end
    endtask

    task automatic tick();
        @(negedge clk);
        ahb_slave_step();
    endtask

    // one request through the DUT checked against the reference model
    task automatic run_op(input mem_op_t o, input hsize_t sz, input bit st, input word_t a,
                          input word_t d);
        bit        mis;
        bit        to_spm;
        int        idx;
        int        edges;
        word_t     mk;
        word_t     want_rd;
        exp_code_t want_exp;
        mis      = (sz == HSIZE_HALF && a[0]) || (sz == HSIZE_WORD && a[1:0] != 2'b00);
        to_spm   = (a[31:12] == SPM_REGION);
        idx      = to_spm ? int'(a[11:2]) : int'(a[7:2]);
        mk       = lane_bits(sz, a[1:0]);
        want_rd  = '0;
        want_exp = EXP_NONE;
        if (mis) begin
            want_exp = st ? EXP_STORE_MISALIGN : EXP_LOAD_MISALIGN;
        end else if (!to_spm && idx >= ERR_FIRST) begin
            want_exp = EXP_BUS_ERROR;
        end else if (st && to_spm) begin
            ref_spm[idx] = (ref_spm[idx] & ~mk) | (shift_to_lane(d, a[1:0]) & mk);
        end else if (st) begin
            ref_ahb[idx] = (ref_ahb[idx] & ~mk) | (shift_to_lane(d, a[1:0]) & mk);
        end else begin
            want_rd = extend_load(o, to_spm ? ref_spm[idx] : ref_ahb[idx], a[1:0]);
        end
        exp_addr  = a;
        exp_write = st;
        exp_size  = sz;
        exp_wdata = d;
        op        = o;
        addr      = a;
        wdata     = d;
        req       = 1'b1;
        // edges counts rising edges after the one that samples req
        edges     = -1;
        do begin
            tick();
            req = 1'b0;
            edges++;
            if (mis || to_spm) begin
                check_value("htrans", 32'(htrans), 32'(HTRANS_IDLE));
            end
            if (!done) begin
                check_value("busy", 32'(busy), 32'd1);
            end
        end while (!done && edges < TIMEOUT);
        assert (done) else begin
            errors++;
            timed_out = 1'b1;
            $display("no done within %0d cycles of the request to address %h", TIMEOUT, a);
        end
        if (done) begin
            check_value("busy", 32'(busy), 32'd0);
            check_value("exp_code", 32'(exp_code), 32'(want_exp));
            if (st || want_exp == EXP_NONE) begin
                check_value("rdata", rdata, want_rd);
            end
            if (mis) begin
                check_value("latency", edges, 1);
            end else if (to_spm) begin
                check_value("latency", edges, 2);
            end
        end
    endtask

    task automatic random_op();
        int         sz;
        bit         st;
        bit         mis;
        logic [1:0] lsb;
        mem_op_t    o;
        word_t      a;
        st  = rand_below(2) == 1;
        sz  = rand_below(3);
        mis = rand_below(8) == 0;
        if (mis && sz == 0) begin
            sz = 1 + rand_below(2);
        end
        lsb = 2'(rand_below(4));
        if (sz == 1) begin
            lsb[0] = mis;
        end else if (sz == 2) begin
            lsb = mis ? 2'(1 + rand_below(3)) : 2'b00;
        end
        if (st) begin
            o = (sz == 0) ? MEM_SB : (sz == 1) ? MEM_SH : MEM_SW;
        end else if (rand_below(2) == 1) begin
            o = (sz == 0) ? MEM_LBU : (sz == 1) ? MEM_LHU : MEM_LW;
        end else begin
            o = (sz == 0) ? MEM_LB : (sz == 1) ? MEM_LH : MEM_LW;
        end
        if (rand_below(2) == 1) begin
            a = SPM_BASE + 32'(4 * rand_below(SPM_WORDS));
        end else begin
            a = AHB_BASE + 32'(4 * rand_below(AHB_WORDS));
        end
        a[1:0] = lsb;
        run_op(o, hsize_t'(sz), st, a, $random(seed));
        // a rejected store must leave its word untouched
        if (st && mis && !timed_out) begin
            run_op(MEM_LW, HSIZE_WORD, 1'b0, {a[31:2], 2'b00}, '0);
        end
    endtask

    initial begin
        seed      = 34325;
        errors    = 0;
        timed_out = 1'b0;
        rst_n     = 1'b0;
        req       = 1'b0;
        op        = MEM_NOP;
        addr      = '0;
        wdata     = '0;
        hrdata    = '0;
        hready    = 1'b1;
        hresp     = HRESP_OKAY;
        dp_active = 1'b0;
        dp_addr   = '0;
        dp_size   = HSIZE_WORD;
        // slave and model start from the same image
        for (int i = 0; i < 64; i++) begin
            ahb_mem[i] = (AHB_BASE + 32'(4 * i)) ^ 32'h5a5a_c3c3;
            ref_ahb[i] = ahb_mem[i];
        end
        repeat (8) tick();
        rst_n = 1'b1;
        tick();
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("htrans", 32'(htrans), 32'(HTRANS_IDLE));
        // scratchpad words written before any load reads them
        for (int i = 0; i < SPM_WORDS && !timed_out; i++) begin
            run_op(MEM_SW, HSIZE_WORD, 1'b1, SPM_BASE + 32'(4 * i), $random(seed));
        end
        for (int n = 0; n < NUM_OPS && !timed_out; n++) begin
            random_op();
        end
        for (int i = 0; i < AHB_WORDS; i++) begin
            check_value($sformatf("ahb_mem[%0d]", i), ahb_mem[i], ref_ahb[i]);
        end
        $display("%0d errors after %0d random operations", errors, NUM_OPS);
        if (errors == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
lsu_pkg.sv
lsu_align.sv
spm.sv
ahb_master.sv
load_store_unit.sv
lsu_assertions.sv
tb_load_store_unit.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_load_store_unit -f verilog.f
./obj_dir/Vtb_load_store_unit 2>&1 | tee sim.log
if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi
